//--- cpu_pkg.sv
// CPU core shared definitions
// Sequencer states, ALU operations and register indices for the 6502 subset core

package cpu_pkg;

    // Cycle states, one path per addressing mode
    typedef enum logic [5:0] {
        DECODE, // Opcode on di, write back previous result
        FETCH,  // Operand on di, ALU runs, fetch next opcode
        IMM0,   // Spare immediate slot
        ZP0,    // Zero page address on bus
        ZP1,    // Spare zero page slot
        JMP0,   // Fetch target low byte
        JMP1,   // Fetch target high byte, jump
        REG,    // Register to register operation
        BRA0,   // Offset on di, add to PC low
        BRA1,   // Same page target, adjust high byte
        BRA2    // Page crossed, fetch at fixed target
    } state_e;

    // ALU function select, logic ops carry the opcode's bits 6:5
    typedef enum logic [3:0] {
        OP_OR   = 4'b1100,
        OP_AND  = 4'b1101,
        OP_EOR  = 4'b1110,
        OP_ADD  = 4'b0011,
        OP_SUB  = 4'b0111,
        OP_PASS = 4'b1111 // Input A straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A = 2'd0,
        SEL_X = 2'd1,
        SEL_Y = 2'd2
    } reg_sel_e;

    localparam logic [7:0] ZERO_PAGE = 8'h00; // High address byte of zero page

endpackage

//--- alu.sv
// 8-bit ALU
// Add, subtract and logic ops with registered result and flags
`timescale 1ns/1ps

module alu (
    input  logic              clk,
    input  cpu_pkg::alu_op_e  op,
    input  logic [7:0]        ai,
    input  logic [7:0]        bi,
    input  logic              ci,
    output logic [7:0]        alu_out,
    output logic              alu_co,
    output logic              alu_v,
    output logic              alu_z,
    output logic              alu_n
);
    import cpu_pkg::*;

    logic [7:0] b_eff;
    logic [8:0] sum;
    logic [7:0] result;

    always_comb begin
        b_eff = (op == OP_SUB) ? ~bi : bi; // Subtract as add of complement
        sum   = {1'b0, ai} + {1'b0, b_eff} + {8'd0, ci};
        case (op)
            OP_OR:   result = ai | bi;
            OP_AND:  result = ai & bi;
            OP_EOR:  result = ai ^ bi;
            OP_PASS: result = ai;
            default: result = sum[7:0];
        endcase
    end

    always_ff @(posedge clk) begin
        alu_out <= result;
        alu_co  <= sum[8];
        alu_v   <= (ai[7] == b_eff[7]) && (sum[7] != ai[7]); // Sign flip on like signs
        alu_z   <= (result == 8'h00);
        alu_n   <= result[7];
    end

endmodule

//--- sequencer.sv
// Instruction sequencer
// Walks the cycle sequence of each addressing mode, dispatching on the opcode
`timescale 1ns/1ps

module sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        ir,        // Opcode, valid in DECODE
    input  logic              cond_true, // Branch condition met
    input  logic              alu_co,    // Carry of PC low byte add
    input  logic              backwards, // Branch offset negative
    output cpu_pkg::state_e   state
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH; // Starts by fetching at the reset PC
        end else begin
            case (state)
                DECODE: begin
                    casez (ir)
                        8'b0100_1100: state <= JMP0;  // JMP abs
                        8'b1010_00?0,                 // LDY, LDX imm
                        8'b???0_1001: state <= FETCH; // Column 9 imm
                        8'b10?0_01??: state <= ZP0;   // Loads and stores zp
                        8'b???1_0000: state <= BRA0;  // Odd 0 column
                        default:      state <= REG;   // Implied, unknown as NOP
                    endcase
                end

                ZP0:    state <= FETCH;

                FETCH,
                REG:    state <= DECODE;

                JMP0:   state <= JMP1;
                JMP1:   state <= DECODE;

                BRA0:   state <= cond_true ? BRA1 : DECODE;
                // Carry out disagrees with offset sign when the page changes
                BRA1:   state <= (alu_co ^ backwards) ? BRA2 : DECODE;
                BRA2:   state <= DECODE;

                default: state <= FETCH;
            endcase
        end
    end

endmodule

//--- decoder.sv
// Instruction decoder
// Latches per-instruction control flags from the opcode during DECODE
`timescale 1ns/1ps

module decoder (
    input  logic               clk,
    input  cpu_pkg::state_e    state,
    input  logic [7:0]         ir,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::reg_sel_e  src_reg,   // Read register in FETCH, REG, ZP0
    output cpu_pkg::reg_sel_e  dst_reg,   // Written at next DECODE
    output logic               load_reg,
    output logic               store,
    output logic               load_only,
    output logic               compare,
    output logic               adc_sbc,
    output logic               inc_dec,
    output logic               clc,
    output logic               sec,
    output logic               clv,
    output logic [2:0]         cond_code
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            cond_code <= ir[7:5];                             // Branch flag and polarity
            load_only <= (ir[7:5] == 3'b101);                 // LDA, LDX, LDY
            store     <= (ir == 8'h84) | (ir == 8'h85) | (ir == 8'h86);
            compare   <= (ir == 8'hc9);
            adc_sbc   <= (ir == 8'h69) | (ir == 8'he9);
            inc_dec   <= (ir == 8'he8) | (ir == 8'hc8) | (ir == 8'hca) | (ir == 8'h88);
            clc       <= (ir == 8'h18);
            sec       <= (ir == 8'h38);
            clv       <= (ir == 8'hb8);

            casez (ir)
                8'b0??0_1001,               // ORA, AND, EOR, ADC imm
                8'b1?10_1001,               // LDA, SBC imm
                8'b1010_00?0,               // LDY, LDX imm
                8'b1010_01??,               // LDA, LDX, LDY zp
                8'b1010_10?0,               // TAY, TAX
                8'b1?00_1000,               // DEY, INY
                8'b1110_1000,               // INX
                8'b1100_1010,               // DEX
                8'b1000_1010,               // TXA
                8'b1001_1000: load_reg <= 1'b1; // TYA
                default:      load_reg <= 1'b0;
            endcase

            case (ir)
                8'ha2, 8'ha6, 8'haa, 8'he8, 8'hca: dst_reg <= SEL_X;
                8'ha0, 8'ha4, 8'ha8, 8'hc8, 8'h88: dst_reg <= SEL_Y;
                default:                           dst_reg <= SEL_A;
            endcase

            case (ir)
                8'h86, 8'h8a, 8'he8, 8'hca: src_reg <= SEL_X; // STX, TXA, INX, DEX
                8'h84, 8'h98, 8'hc8, 8'h88: src_reg <= SEL_Y; // STY, TYA, INY, DEY
                default:                    src_reg <= SEL_A;
            endcase

            case (ir)
                8'h09, 8'h29, 8'h49: alu_op <= alu_op_e'({2'b11, ir[6:5]});
                8'he9, 8'hc9,                     // SBC, CMP
                8'hca, 8'h88:        alu_op <= OP_SUB; // DEX, DEY
                8'haa, 8'ha8, 8'h8a, 8'h98,       // Transfers
                8'h18, 8'h38, 8'hb8: alu_op <= OP_PASS;
                default:             alu_op <= OP_ADD; // Loads, ADC, INX, branches, JMP
            endcase
        end
    end

endmodule

//--- program_counter.sv
// Program counter
// Increments, or loads jump and branch targets, one state at a time
`timescale 1ns/1ps

module program_counter #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::state_e  state,
    input  logic [7:0]       di,
    input  logic [7:0]       alu_out,   // Registered target byte
    input  logic             alu_co,
    input  logic [7:0]       addr_hi,   // Address bus high byte
    output logic [15:0]      pc,
    output logic             backwards  // Branch offset sign
);
    import cpu_pkg::*;

    logic [15:0] pc_base;
    logic        pc_inc;

    always_comb begin
        pc_base = pc;
        pc_inc  = 1'b0;
        case (state)
            DECODE,
            FETCH,
            BRA0:   pc_inc = 1'b1;
            JMP1: begin
                pc_base = {di, alu_out}; // High byte arrives now, low held in ALU
                pc_inc  = 1'b1;
            end
            BRA1: begin
                pc_base = {addr_hi, alu_out};
                pc_inc  = ~(alu_co ^ backwards); // Hold if high byte still to fix
            end
            BRA2: begin
                pc_base = {alu_out, pc[7:0]};
                pc_inc  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_base + {15'd0, pc_inc};
        end
    end

    always_ff @(posedge clk) begin
        if (state == BRA0) begin
            backwards <= di[7];
        end
    end

endmodule

//--- register_file.sv
// Register file and status flags
// Holds A, X, Y and N, V, Z, C, feeds the ALU inputs and evaluates branches
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::state_e    state,
    input  cpu_pkg::reg_sel_e  src_reg,
    input  cpu_pkg::reg_sel_e  dst_reg,
    input  cpu_pkg::alu_op_e   alu_op,
    input  logic               load_reg,
    input  logic               load_only,
    input  logic               compare,
    input  logic               adc_sbc,
    input  logic               inc_dec,
    input  logic               clc,
    input  logic               sec,
    input  logic               clv,
    input  logic [2:0]         cond_code,
    input  logic [7:0]         di,
    input  logic [7:0]         pc_lo,
    input  logic [7:0]         addr_hi,   // Branch base high byte in BRA1
    input  logic               backwards,
    input  logic [7:0]         alu_out,
    input  logic               alu_co,
    input  logic               alu_v,
    input  logic               alu_z,
    input  logic               alu_n,
    output logic [7:0]         reg_out,
    output logic [7:0]         ai,
    output logic [7:0]         bi,
    output logic               carry,     // ALU carry in
    output logic               cond_true
);
    import cpu_pkg::*;

    logic [7:0] regs [0:2]; // A, X, Y
    reg_sel_e   reg_sel;
    logic       started;    // Low until first opcode decoded
    logic       n_flag;
    logic       v_flag;
    logic       z_flag;
    logic       c_flag;

    assign reg_sel = (state == DECODE) ? dst_reg : src_reg;
    assign reg_out = regs[reg_sel];

    always_comb begin
        ai    = 8'h00;
        bi    = di;
        carry = 1'b0;
        case (state)
            FETCH: begin
                ai    = load_only ? 8'h00 : reg_out;
                carry = compare | (~load_only & c_flag);
            end
            REG: begin
                ai    = reg_out;
                bi    = 8'h00;
                carry = inc_dec & (alu_op == OP_ADD); // INX, INY add one
            end
            BRA0: begin
                ai = di;     // Offset plus PC low byte
                bi = pc_lo;
            end
            BRA1: begin
                ai    = addr_hi;
                bi    = {8{backwards}}; // Sign extension of offset
                carry = alu_co;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
            n_flag  <= 1'b0;
            v_flag  <= 1'b0;
            z_flag  <= 1'b0;
            c_flag  <= 1'b0;
            for (int i = 0; i < 3; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (state == DECODE) begin
            started <= 1'b1;
            if (started) begin // Previous instruction retires here
                if (load_reg) begin
                    regs[reg_sel] <= alu_out;
                end
                if (load_reg | compare) begin
                    n_flag <= alu_n;
                    z_flag <= alu_z;
                end
                if (adc_sbc | compare) begin
                    c_flag <= alu_co;
                end else if (sec) begin
                    c_flag <= 1'b1;
                end else if (clc) begin
                    c_flag <= 1'b0;
                end
                if (adc_sbc) begin
                    v_flag <= alu_v;
                end else if (clv) begin
                    v_flag <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        case (cond_code)
            3'b000:  cond_true = ~n_flag; // BPL
            3'b001:  cond_true = n_flag;  // BMI
            3'b010:  cond_true = ~v_flag; // BVC
            3'b011:  cond_true = v_flag;  // BVS
            3'b100:  cond_true = ~c_flag; // BCC
            3'b101:  cond_true = c_flag;  // BCS
            3'b110:  cond_true = ~z_flag; // BNE
            default: cond_true = z_flag;  // BEQ
        endcase
    end

endmodule

//--- bus_unit.sv
// Memory bus unit
// Address and write data muxes, with a latch of the previous address
`timescale 1ns/1ps

module bus_unit (
    input  logic             clk,
    input  cpu_pkg::state_e  state,
    input  logic [15:0]      pc,
    input  logic [7:0]       di,
    input  logic [7:0]       alu_out,
    input  logic [7:0]       reg_out,
    input  logic             store,
    output logic [15:0]      ab,
    output logic [7:0]       do_data,
    output logic             we
);
    import cpu_pkg::*;

    logic [15:0] ab_hold; // Address of the previous cycle

    always_comb begin
        case (state)
            ZP0:     ab = {ZERO_PAGE, di};
            JMP1:    ab = {di, alu_out};
            BRA1:    ab = {ab_hold[15:8], alu_out}; // Same page guess
            BRA2:    ab = {alu_out, ab_hold[7:0]};  // Corrected high byte
            REG:     ab = ab_hold;                  // Next opcode, PC already past it
            default: ab = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        ab_hold <= ab;
    end

    assign do_data = reg_out;
    assign we      = (state == ZP0) & store; // STA, STX, STY zp

endmodule

//--- cpu_top.sv
// 6502 subset CPU core top level
// Connects sequencer, decoder, PC, ALU, register file and memory bus unit
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [15:0] RESET_PC = 16'h0200 // First opcode address
) (
    input  logic        clk,
    input  logic        reset,
    output logic [15:0] ab,      // Address bus
    input  logic [7:0]  di,      // Read data, one cycle after ab
    output logic [7:0]  do_data, // Write data
    output logic        we       // Write enable
);
    import cpu_pkg::*;

    state_e      state;
    alu_op_e     alu_op;
    reg_sel_e    src_reg;
    reg_sel_e    dst_reg;
    logic        load_reg;
    logic        store;
    logic        load_only;
    logic        compare;
    logic        adc_sbc;
    logic        inc_dec;
    logic        clc;
    logic        sec;
    logic        clv;
    logic [2:0]  cond_code;
    logic [15:0] pc;
    logic        backwards;
    logic [7:0]  ai;
    logic [7:0]  bi;
    logic        carry;     // ALU carry in
    logic [7:0]  alu_out;
    logic        alu_co;
    logic        alu_v;
    logic        alu_z;
    logic        alu_n;
    logic [7:0]  reg_out;
    logic        cond_true;

    sequencer u_sequencer (
        .clk(clk), .reset(reset), .ir(di), .cond_true(cond_true),
        .alu_co(alu_co), .backwards(backwards), .state(state)
    );

    decoder u_decoder (
        .clk(clk), .state(state), .ir(di), .alu_op(alu_op),
        .src_reg(src_reg), .dst_reg(dst_reg), .load_reg(load_reg),
        .store(store), .load_only(load_only), .compare(compare),
        .adc_sbc(adc_sbc), .inc_dec(inc_dec), .clc(clc), .sec(sec),
        .clv(clv), .cond_code(cond_code)
    );

    program_counter #(.RESET_PC(RESET_PC)) u_program_counter (
        .clk(clk), .reset(reset), .state(state), .di(di), .alu_out(alu_out),
        .alu_co(alu_co), .addr_hi(ab[15:8]), .pc(pc), .backwards(backwards)
    );

    alu u_alu (
        .clk(clk), .op(alu_op), .ai(ai), .bi(bi), .ci(carry),
        .alu_out(alu_out), .alu_co(alu_co), .alu_v(alu_v),
        .alu_z(alu_z), .alu_n(alu_n)
    );

    register_file u_register_file (
        .clk(clk), .reset(reset), .state(state), .src_reg(src_reg),
        .dst_reg(dst_reg), .alu_op(alu_op), .load_reg(load_reg),
        .load_only(load_only), .compare(compare), .adc_sbc(adc_sbc),
        .inc_dec(inc_dec), .clc(clc), .sec(sec), .clv(clv),
        .cond_code(cond_code), .di(di), .pc_lo(pc[7:0]), .addr_hi(ab[15:8]),
        .backwards(backwards), .alu_out(alu_out), .alu_co(alu_co),
        .alu_v(alu_v), .alu_z(alu_z), .alu_n(alu_n), .reg_out(reg_out),
        .ai(ai), .bi(bi), .carry(carry), .cond_true(cond_true)
    );

    bus_unit u_bus_unit (
        .clk(clk), .state(state), .pc(pc), .di(di), .alu_out(alu_out),
        .reg_out(reg_out), .store(store), .ab(ab), .do_data(do_data), .we(we)
    );

endmodule

//--- tb_cpu_sva.sv
// Bus and reset checks for the CPU core
// Bound to cpu_top, watches the external memory bus only
`timescale 1ns/1ps

module tb_cpu_sva #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input logic        clk,
    input logic        reset,
    input logic [15:0] ab,
    input logic        we
);

    // First cycle out of reset fetches the start address, no write
    property reset_fetch_p;
        @(posedge clk) $fell(reset) |-> (ab == RESET_PC) && !we;
    endproperty

    property we_known_p;
        @(posedge clk) disable iff (reset) !$isunknown(we);
    endproperty

    // Stores only use zero page addressing
    property zero_page_write_p;
        @(posedge clk) disable iff (reset) we |-> (ab[15:8] == 8'h00);
    endproperty

    property single_cycle_write_p;
        @(posedge clk) disable iff (reset) we |=> !we; // One ZP0 cycle per store
    endproperty

    assert property (reset_fetch_p) else $error("Bus not at start address after reset");
    assert property (we_known_p) else $error("Write enable is unknown");
    assert property (zero_page_write_p) else $error("Write outside zero page");
    assert property (single_cycle_write_p) else $error("Write enable held two cycles");

endmodule

bind cpu_top tb_cpu_sva #(.RESET_PC(RESET_PC)) u_sva (
    .clk(clk), .reset(reset), .ab(ab), .we(we)
);

//--- tb_cpu.sv
// Testbench for the 6502 subset CPU core
// Random program in memory, instruction level model, write by write compare
`timescale 1ns/1ps

module tb_cpu;

    localparam logic [15:0] RESET_PC   = 16'h0200;
    localparam int          NUM_INSTR  = 300;
    localparam int          MAX_WRITES = 1024;
    localparam logic [7:0]  LOAD_IMM [3] = '{8'ha9, 8'ha2, 8'ha0};
    localparam logic [7:0]  LOAD_ZP  [3] = '{8'ha5, 8'ha6, 8'ha4};
    localparam logic [7:0]  STORE_ZP [3] = '{8'h85, 8'h86, 8'h84};
    localparam logic [7:0]  ALU_IMM  [6] = '{8'h69, 8'he9, 8'h29, 8'h09, 8'h49, 8'hc9};
    localparam logic [7:0]  REG_OPS  [8] = '{8'he8, 8'hc8, 8'hca, 8'h88,
                                             8'haa, 8'ha8, 8'h8a, 8'h98};
    localparam logic [7:0]  FLAG_OPS [3] = '{8'h18, 8'h38, 8'hb8};
    localparam logic [7:0]  BRANCHES [8] = '{8'h10, 8'h30, 8'h50, 8'h70,
                                             8'h90, 8'hb0, 8'hd0, 8'hf0};

    logic        clk;
    logic        reset;
    logic [15:0] ab;
    logic [7:0]  di;
    logic [7:0]  do_data;
    logic        we;
    logic [7:0]  mem [0:65535];     // Memory seen by the DUT
    logic [7:0]  ref_mem [0:65535]; // Model's own copy
    logic [15:0] rd_addr;           // Address of the previous cycle
    logic [15:0] gen_pc;            // Generator write pointer
    logic [15:0] exp_addr [0:MAX_WRITES-1];
    logic [7:0]  exp_data [0:MAX_WRITES-1];
    integer      seed;
    int          exp_count;
    int          ref_steps;
    int          wr_idx;
    int          cycles;
    int          timeout_limit;

    cpu_top #(.RESET_PC(RESET_PC)) DUT (
        .clk(clk), .reset(reset), .ab(ab), .di(di), .do_data(do_data), .we(we)
    );

    function automatic int rand_below(int range);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % range;
    endfunction

    task automatic emit(input logic [7:0] b);
        mem[gen_pc] = b;
        gen_pc = gen_pc + 16'd1;
    endtask

    task automatic emit_marker();
        emit(STORE_ZP[rand_below(3)]);
        emit(8'(rand_below(256))); // Random zp address
    endtask

    task automatic build_program();
        int          k;
        logic [15:0] target;
        logic [7:0]  forced_page;
        gen_pc      = RESET_PC;
        forced_page = 8'h00;
        for (int i = 0; i < NUM_INSTR; i++) begin
            // Near a page end, force one taken branch across it
            if (gen_pc[7:0] >= 8'hf5 && gen_pc[7:0] <= 8'hfb && gen_pc[15:8] != forced_page) begin
                forced_page = gen_pc[15:8];
                emit(8'h38);          // SEC
                emit(8'hb0);          // BCS over four markers
                emit(8'h08);
                repeat (4) emit_marker();
            end else begin
                case (rand_below(12))
                    0: begin
                        emit(LOAD_IMM[rand_below(3)]);
                        emit(8'(rand_below(256)));
                    end
                    1: begin
                        emit(LOAD_ZP[rand_below(3)]);
                        emit(8'(rand_below(256)));
                    end
                    2, 11: emit_marker(); // Plain store
                    3, 4: begin
                        emit(ALU_IMM[rand_below(6)]);
                        emit(8'(rand_below(256)));
                    end
                    5, 6: emit(REG_OPS[rand_below(8)]);
                    7: emit(FLAG_OPS[rand_below(3)]);
                    8, 9: begin
                        k = 1 + rand_below(2);
                        emit(BRANCHES[rand_below(8)]);
                        emit(8'(2 * k)); // Skip k markers
                        repeat (k) emit_marker();
                    end
                    default: begin
                        k      = 1 + rand_below(2);
                        target = gen_pc + 16'(3 + 2 * k);
                        emit(8'h4c);
                        emit(target[7:0]);
                        emit(target[15:8]);
                        repeat (k) emit_marker();
                    end
                endcase
            end
        end
        emit(8'h85);
        emit(8'h10);
        emit(8'h86);
        emit(8'h11);
        emit(8'h84);
        emit(8'h12);
        target = gen_pc;
        emit(8'h4c);             // Park on a jump to itself
        emit(target[7:0]);
        emit(target[15:8]);
    endtask

    // Instruction level 6502 model, fills the expected write list
    function automatic int run_reference();
        logic [15:0] pc;
        logic [15:0] len;
        logic [15:0] target;
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  op;
        logic [7:0]  opnd;
        logic [7:0]  m;
        logic [7:0]  b;
        logic [7:0]  res;
        logic [7:0]  wv;
        logic [8:0]  sum;
        logic        n;
        logic        v;
        logic        z;
        logic        c;
        logic        upd;
        logic        taken;
        logic        halt;
        int          count;
        pc        = RESET_PC;
        {a, x, y} = 24'h0;
        {n, v, z, c} = 4'b0000;
        halt      = 1'b0;
        count     = 0;
        ref_steps = 0;
        while (!halt && ref_steps < 100000) begin
            op   = ref_mem[pc];
            opnd = ref_mem[pc + 16'd1];
            m    = ref_mem[{8'h00, opnd}];
            upd  = 1'b1;
            res  = 8'h00;
            len  = 16'd2;
            ref_steps++;
            case (op)
                8'ha9, 8'ha5: begin
                    a   = (op == 8'ha9) ? opnd : m;
                    res = a;
                end
                8'ha2, 8'ha6: begin
                    x   = (op == 8'ha2) ? opnd : m;
                    res = x;
                end
                8'ha0, 8'ha4: begin
                    y   = (op == 8'ha0) ? opnd : m;
                    res = y;
                end
                8'h85, 8'h86, 8'h84: begin
                    upd = 1'b0;
                    wv  = (op == 8'h85) ? a : (op == 8'h86) ? x : y;
                    ref_mem[{8'h00, opnd}] = wv;
                    exp_addr[count] = {8'h00, opnd};
                    exp_data[count] = wv;
                    count++;
                end
                8'h69, 8'he9: begin
                    b   = (op == 8'he9) ? ~opnd : opnd; // SBC adds the complement
                    sum = {1'b0, a} + {1'b0, b} + {8'd0, c};
                    v   = ~(a[7] ^ b[7]) & (a[7] ^ sum[7]);
                    c   = sum[8];
                    a   = sum[7:0];
                    res = a;
                end
                8'h29: begin
                    a   = a & opnd;
                    res = a;
                end
                8'h09: begin
                    a   = a | opnd;
                    res = a;
                end
                8'h49: begin
                    a   = a ^ opnd;
                    res = a;
                end
                8'hc9: begin
                    sum = {1'b0, a} + {1'b0, ~opnd} + 9'd1;
                    c   = sum[8];  // No borrow when A >= operand
                    res = sum[7:0];
                end
                8'he8, 8'hca: begin
                    x   = (op == 8'he8) ? x + 8'd1 : x - 8'd1;
                    res = x;
                    len = 16'd1;
                end
                8'hc8, 8'h88: begin
                    y   = (op == 8'hc8) ? y + 8'd1 : y - 8'd1;
                    res = y;
                    len = 16'd1;
                end
                8'haa: begin
                    x   = a;
                    res = x;
                    len = 16'd1;
                end
                8'ha8: begin
                    y   = a;
                    res = y;
                    len = 16'd1;
                end
                8'h8a, 8'h98: begin
                    a   = (op == 8'h8a) ? x : y;
                    res = a;
                    len = 16'd1;
                end
                8'h18, 8'h38, 8'hb8: begin
                    if (op == 8'hb8) begin
                        v = 1'b0;
                    end else begin
                        c = (op == 8'h38);
                    end
                    upd = 1'b0;
                    len = 16'd1;
                end
                8'h4c: begin
                    target = {ref_mem[pc + 16'd2], opnd};
                    halt   = (target == pc);
                    pc     = target;
                    upd    = 1'b0;
                    len    = 16'd0;
                end
                default: begin // Branch, bits 7:6 pick the flag, bit 5 its value
                    upd = 1'b0;
                    case (op[7:6])
                        2'd0:    taken = (n == op[5]);
                        2'd1:    taken = (v == op[5]);
                        2'd2:    taken = (c == op[5]);
                        default: taken = (z == op[5]);
                    endcase
                    if (taken) begin
                        pc = pc + {{8{opnd[7]}}, opnd};
                    end
                end
            endcase
            if (upd) begin
                n = res[7];
                z = (res == 8'h00);
            end
            pc = pc + len;
        end
        return count;
    endfunction

    task automatic finish_run();
        $display("test passed");
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Synchronous memory, read data one cycle after the address
    always @(posedge clk) begin
        if (we) begin
            mem[ab] <= do_data;
        end
        rd_addr <= ab;
    end

    always @(negedge clk) begin
        di <= mem[rd_addr];
    end

    initial begin
        seed   = 19806;
        reset  = 1'b1;
        di     = 8'h00;
        wr_idx = 0;
        cycles = 0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i[7:0] ^ i[15:8] ^ 8'h5a); // Whole address in fill
        end
        build_program();
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = mem[i];
        end
        exp_count     = run_reference();
        timeout_limit = 4 * ref_steps + 100;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    end

    // Compare each DUT write with the next expected one
    always @(posedge clk) begin
        if (!reset) begin
            cycles = cycles + 1;
            if (we) begin
                assert (wr_idx < exp_count && ab == exp_addr[wr_idx]
                        && do_data == exp_data[wr_idx])
                else begin
                    $display("** Error at %0t ns: write %0d got [%h]=%h, expected [%h]=%h",
                             $time, wr_idx, ab, do_data, exp_addr[wr_idx], exp_data[wr_idx]);
                    $display("test failed");
                    $fatal(1, "Write mismatch");
                end
                wr_idx = wr_idx + 1;
            end
            assert (cycles < timeout_limit)
            else begin
                $display("Timeout after %0d cycles, only %0d of %0d writes seen",
                         cycles, wr_idx, exp_count);
                $display("test failed");
                $fatal(1, "Timeout");
            end
            if (wr_idx == exp_count) begin
                finish_run();
            end
        end
    end

endmodule

//--- tb.f
cpu_pkg.sv
alu.sv
sequencer.sv
decoder.sv
program_counter.sv
register_file.sv
bus_unit.sv
cpu_top.sv
tb_cpu_sva.sv
tb_cpu.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cpu
FILELIST = tb.f
SRCS     = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "Simulation ended without result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
